// ==== include/audio_settings.svh ====
/*
  Audio sample store sizing
  Geometry of the shared sample ROM and the slot layout of one sequencer frame
*/

`ifndef AUDIO_SETTINGS_SVH
`define AUDIO_SETTINGS_SVH

// Shared sample ROM
`define ROM_DEPTH   1024
`define ROM_ADDR_W  10      // log2 of ROM_DEPTH

// Frame layout of the slot sequencer
// Slots 0 to 2 carry song0, song1 and bee
`define FRAME_SLOTS 5       // Two idle slots at the end
`define VOICE_COUNT 3

`endif

// ==== rtl/audio_pkg.sv ====
/*
  Audio sample store types
  Voice request and ROM read structs, sample payloads and the tone-table rule
*/

`include "audio_settings.svh"

package audio_pkg;

    typedef logic [`ROM_ADDR_W-1:0] romAddr_t;

    typedef logic [7:0]  sample8_t;     // song0 and bee payload
    typedef logic [15:0] sample16_t;    // song1 payload, also the ROM word

    // One voice asking for a sample inside its own region
    typedef struct packed {
        logic [15:0] index;
        logic [15:0] length;
    } voiceReq_t;

    typedef struct packed {
        voiceReq_t song0;
        voiceReq_t song1;
        voiceReq_t bee;
    } voiceReqs_t;

    // Read in flight, travels beside the ROM address
    typedef struct packed {
        logic [1:0] voice;
        logic       en;
    } romRead_t;

    // Contents of the sample ROM
    // High byte is the inverted low address byte, low byte is three times it
    function automatic sample16_t toneWord(input romAddr_t addr);
        logic [7:0] lowByte;
        logic [7:0] tripled;
        lowByte = addr[7:0];
        tripled = lowByte * 8'd3;   // Wraps modulo 256
        return {~lowByte, tripled};
    endfunction

endpackage

// ==== rtl/slotSequencer.sv ====
/*
  Slot sequencer for the shared sample ROM
  Steps the frame slots, places each voice inside its region and issues the
  ROM address with a tag that follows the word back out of the ROM
*/

`timescale 1ns/10ps
`include "audio_settings.svh"

module slotSequencer (
    input  logic                  CLK_50Mhz,
    input  logic                  reset_n,
    input  audio_pkg::voiceReqs_t reqs,
    output audio_pkg::romAddr_t   romAddr,
    output audio_pkg::romRead_t   readTag,
    output audio_pkg::romRead_t   returnTag
);

    localparam int SLOT_W = $clog2(`FRAME_SLOTS);
    localparam int SUM_W  = 18;     // Two lengths plus an index never overflow

    logic [SLOT_W-1:0]    slotCount;
    audio_pkg::voiceReq_t curReq;
    logic [SUM_W-1:0]     regionBase;
    logic [SUM_W-1:0]     sampleAddr;
    logic                 voiceSlot;
    logic                 inRange;

    // Voice owning the current slot and where its region starts
    always_comb begin
        voiceSlot = (slotCount < SLOT_W'(`VOICE_COUNT));
        case (slotCount)
            SLOT_W'(0): begin
                curReq     = reqs.song0;
                regionBase = '0;
            end
            SLOT_W'(1): begin
                curReq     = reqs.song1;
                regionBase = SUM_W'(reqs.song0.length);
            end
            SLOT_W'(2): begin
                curReq     = reqs.bee;
                regionBase = SUM_W'(reqs.song0.length) + SUM_W'(reqs.song1.length);
            end
            default: begin      // Idle slots
                curReq     = '0;
                regionBase = '0;
            end
        endcase
    end

    // Range check against the voice's own length and the ROM size
    always_comb begin
        sampleAddr = regionBase + SUM_W'(curReq.index);
        inRange    = voiceSlot
                     && (curReq.index < curReq.length)
                     && (sampleAddr < SUM_W'(`ROM_DEPTH));
    end

    always_ff @(posedge CLK_50Mhz, negedge reset_n) begin
        if (!reset_n) begin
            slotCount <= '0;
            romAddr   <= '0;
            readTag   <= '0;
            returnTag <= '0;
        end
        else begin
            if (slotCount == SLOT_W'(`FRAME_SLOTS - 1)) begin
                slotCount <= '0;
            end
            else begin
                slotCount <= slotCount + 1'b1;
            end

            // Skipped reads leave the address where it was
            if (inRange) begin
                romAddr <= sampleAddr[`ROM_ADDR_W-1:0];
            end
            readTag.voice <= slotCount[1:0];
            readTag.en    <= inRange;

            returnTag <= readTag;   // Lines up with romWord
        end
    end

endmodule

// ==== rtl/sampleRom.sv ====
/*
  Sample ROM
  Registered-read model of the vendor ROM, one cycle from address to word
*/

`timescale 1ns/10ps
`include "audio_settings.svh"

module sampleRom (
    input  logic                 CLK_50Mhz,
    input  audio_pkg::romAddr_t  romAddr,
    output audio_pkg::sample16_t romWord
);

    audio_pkg::sample16_t romData [`ROM_DEPTH];

    // Contents follow the tone-table rule
    initial begin
        for (int a = 0; a < `ROM_DEPTH; a++) begin
            romData[a] = audio_pkg::toneWord(audio_pkg::romAddr_t'(a));
        end
    end

    always_ff @(posedge CLK_50Mhz) begin
        romWord <= romData[romAddr];    // Same latency as the vendor part
    end

endmodule

// ==== rtl/voiceLatch.sv ====
/*
  Voice sample latch
  Holds the latest ROM word returned for one voice and pulses on each refresh
*/

`timescale 1ns/10ps

module voiceLatch #(
    parameter type sample_t = audio_pkg::sample8_t,
    parameter int  VOICE    = 0
) (
    input  logic                 CLK_50Mhz,
    input  logic                 reset_n,
    input  audio_pkg::romRead_t  returnTag,
    input  audio_pkg::sample16_t romWord,
    output sample_t              sample,
    output logic                 update
);

    localparam int SAMPLE_W = $bits(sample_t);

    logic    hit;
    sample_t narrowWord;

    assign hit        = returnTag.en && (returnTag.voice == 2'(VOICE));
    assign narrowWord = sample_t'(romWord[SAMPLE_W-1:0]);  // 8-bit voices keep the low byte

    always_ff @(posedge CLK_50Mhz, negedge reset_n) begin
        if (!reset_n) begin
            sample <= '0;
            update <= 1'b0;
        end
        else begin
            update <= hit;      // One cycle per captured word
            if (hit) begin
                sample <= narrowWord;
            end
        end
    end

endmodule

// ==== rtl/audioRomSubsystem.sv ====
/*
  Audio sample store
  Three voices share one sample ROM through a fixed five-slot frame
*/

`timescale 1ns/10ps

module audioRomSubsystem (
    input  logic                  CLK_50Mhz,
    input  logic                  reset_n,
    input  audio_pkg::voiceReqs_t reqs,

    output audio_pkg::sample8_t   song0Sample,
    output audio_pkg::sample16_t  song1Sample,
    output audio_pkg::sample8_t   beeSample,

    output logic                  song0Update,
    output logic                  song1Update,
    output logic                  beeUpdate
);

    audio_pkg::romAddr_t  romAddr;
    audio_pkg::romRead_t  readTag;
    audio_pkg::romRead_t  returnTag;
    audio_pkg::sample16_t romWord;

    // Decode
    slotSequencer slotSeq (
        .CLK_50Mhz (CLK_50Mhz),
        .reset_n   (reset_n),
        .reqs      (reqs),
        .romAddr   (romAddr),
        .readTag   (readTag),
        .returnTag (returnTag)
    );

    // Execute
    sampleRom rom (
        .CLK_50Mhz (CLK_50Mhz),
        .romAddr   (romAddr),
        .romWord   (romWord)
    );

    // Result stage, one latch per voice slot
    voiceLatch #(
        .sample_t (audio_pkg::sample8_t),
        .VOICE    (0)
    ) song0Latch (
        .CLK_50Mhz (CLK_50Mhz),
        .reset_n   (reset_n),
        .returnTag (returnTag),
        .romWord   (romWord),
        .sample    (song0Sample),
        .update    (song0Update)
    );

    voiceLatch #(
        .sample_t (audio_pkg::sample16_t),
        .VOICE    (1)
    ) song1Latch (
        .CLK_50Mhz (CLK_50Mhz),
        .reset_n   (reset_n),
        .returnTag (returnTag),
        .romWord   (romWord),
        .sample    (song1Sample),     // Full word
        .update    (song1Update)
    );

    voiceLatch #(
        .sample_t (audio_pkg::sample8_t),
        .VOICE    (2)
    ) beeLatch (
        .CLK_50Mhz (CLK_50Mhz),
        .reset_n   (reset_n),
        .returnTag (returnTag),
        .romWord   (romWord),
        .sample    (beeSample),
        .update    (beeUpdate)
    );

endmodule

// ==== testbench/audioRom_chk.sv ====
/*
  Slot sequencer checker
  Concurrent assertions on the frame counter, the ROM address and the read tags
*/

`timescale 1ns/10ps
`include "audio_settings.svh"

module audioRom_chk (
    input logic                             CLK_50Mhz,
    input logic                             reset_n,
    input logic [$clog2(`FRAME_SLOTS)-1:0]  slotCount,
    input logic [17:0]                      sampleAddr,     // Unclamped base plus index
    input audio_pkg::romAddr_t              romAddr,
    input audio_pkg::romRead_t              readTag,
    input audio_pkg::romRead_t              returnTag
);

    int assertFails = 0;    // Read by the testbench at the end

    slotInFrame: assert property (@(posedge CLK_50Mhz) disable iff (!reset_n)
        slotCount <= `FRAME_SLOTS - 1)
        else begin
            assertFails++;
            $error("slot counter past the last frame slot");
        end

    // An issued read carries the whole sum, so it never wraps past the ROM end
    addrInRom: assert property (@(posedge CLK_50Mhz) disable iff (!reset_n)
        readTag.en |-> (int'(romAddr) == int'($past(sampleAddr))))
        else begin
            assertFails++;
            $error("ROM address beyond the ROM depth");
        end

    // Tag must follow the ROM latency exactly
    tagDelay: assert property (@(posedge CLK_50Mhz) disable iff (!reset_n)
        returnTag == $past(readTag))
        else begin
            assertFails++;
            $error("returnTag is not readTag delayed by one cycle");
        end

    noIdleRead: assert property (@(posedge CLK_50Mhz) disable iff (!reset_n)
        readTag.en |-> ($past(slotCount) < `VOICE_COUNT))
        else begin
            assertFails++;
            $error("read issued from an idle slot");
        end

endmodule

bind slotSequencer audioRom_chk seqChk (
    .CLK_50Mhz  (CLK_50Mhz),
    .reset_n    (reset_n),
    .slotCount  (slotCount),
    .sampleAddr (sampleAddr),
    .romAddr    (romAddr),
    .readTag    (readTag),
    .returnTag  (returnTag)
);

// ==== testbench/tb_audioRomSubsystem.sv ====
/*
  Testbench for the audio sample store
  Directed tests of reset, region bases, range skips, pulse timing and random reads
*/

`timescale 1ns/10ps
`include "audio_settings.svh"

module tb_audioRomSubsystem;

    localparam int FRAME       = `FRAME_SLOTS;
    // About 160 frames of tests, so 400 frames leaves a wide margin
    localparam int CYCLE_LIMIT = 400 * FRAME;

    logic                  CLK_50Mhz;
    logic                  reset_n;
    audio_pkg::voiceReqs_t reqs;
    audio_pkg::sample8_t   song0Sample;
    audio_pkg::sample16_t  song1Sample;
    audio_pkg::sample8_t   beeSample;
    logic                  song0Update;
    logic                  song1Update;
    logic                  beeUpdate;

    int          errorCount = 0;
    int          cycleCount = 0;
    logic [15:0] lfsrState  = 16'd82;

    audioRomSubsystem uut (
        .CLK_50Mhz   (CLK_50Mhz),
        .reset_n     (reset_n),
        .reqs        (reqs),
        .song0Sample (song0Sample),
        .song1Sample (song1Sample),
        .beeSample   (beeSample),
        .song0Update (song0Update),
        .song1Update (song1Update),
        .beeUpdate   (beeUpdate)
    );

    initial CLK_50Mhz = 1'b0;
    always #10 CLK_50Mhz = ~CLK_50Mhz;     // 50 MHz

    always @(posedge CLK_50Mhz) begin
        cycleCount++;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with tests still running", cycleCount);
            $display("Errors: %0d", errorCount);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // Galois LFSR, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    task automatic randomBits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsrState[0]);
            lfsrState = lfsrNext(lfsrState);    // One step per bit
        end
    endtask

    // ROM contents, inverted low byte above three times the low byte
    function automatic logic [15:0] toneRule(input int addr);
        logic [7:0] lowByte;
        logic [7:0] tripled;
        lowByte = 8'(addr % 256);
        tripled = 8'((int'(lowByte) * 3) % 256);
        return {~lowByte, tripled};
    endfunction

    function automatic int regionBase(input int voice, input audio_pkg::voiceReqs_t r);
        case (voice)
            0:       return 0;
            1:       return int'(r.song0.length);
            default: return int'(r.song0.length) + int'(r.song1.length);
        endcase
    endfunction

    function automatic int voiceIndex(input int voice, input audio_pkg::voiceReqs_t r);
        case (voice)
            0:       return int'(r.song0.index);
            1:       return int'(r.song1.index);
            default: return int'(r.bee.index);
        endcase
    endfunction

    function automatic logic [15:0] expectedSample(input int voice,
                                                   input audio_pkg::voiceReqs_t r);
        logic [15:0] word;
        word = toneRule(regionBase(voice, r) + voiceIndex(voice, r));
        return (voice == 1) ? word : {8'h00, word[7:0]};    // 8-bit voices keep low byte
    endfunction

    function automatic logic [15:0] voiceSample(input int voice);
        case (voice)
            0:       return {8'h00, song0Sample};
            1:       return song1Sample;
            default: return {8'h00, beeSample};
        endcase
    endfunction

    function automatic logic voicePulse(input int voice);
        case (voice)
            0:       return song0Update;
            1:       return song1Update;
            default: return beeUpdate;
        endcase
    endfunction

    function automatic string sampleName(input int voice);
        string names [3] = '{"song0Sample", "song1Sample", "beeSample"};
        return names[voice];
    endfunction

    function automatic string pulseName(input int voice);
        string names [3] = '{"song0Update", "song1Update", "beeUpdate"};
        return names[voice];
    endfunction

    task automatic checkValue(input string name, input logic [15:0] actual,
                              input logic [15:0] expected);
        if (actual !== expected) begin
            errorCount++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, actual, expected);
        end
    endtask

    task automatic driveReqs(input audio_pkg::voiceReqs_t newReqs);
        @(posedge CLK_50Mhz);
        reqs <= newReqs;
    endtask

    // Two frames flush every read issued with the old requests
    task automatic settle();
        repeat (2 * FRAME) @(posedge CLK_50Mhz);
    endtask

    task automatic checkVoice(input int voice);
        bit seen;
        seen = 1'b0;
        for (int c = 0; c < 2 * FRAME && !seen; c++) begin
            @(negedge CLK_50Mhz);
            seen = voicePulse(voice);
        end
        if (!seen) begin
            errorCount++;
            $display("No update pulse from %s within two frames", pulseName(voice));
        end
        else begin
            checkValue(sampleName(voice), voiceSample(voice), expectedSample(voice, reqs));
        end
    endtask

    function automatic audio_pkg::voiceReqs_t makeReqs(input int i0, input int l0,
                                                       input int i1, input int l1,
                                                       input int i2, input int l2);
        audio_pkg::voiceReqs_t r;
        r.song0 = '{index: 16'(i0), length: 16'(l0)};
        r.song1 = '{index: 16'(i1), length: 16'(l1)};
        r.bee   = '{index: 16'(i2), length: 16'(l2)};
        return r;
    endfunction

    // Zero lengths keep every voice out of range after reset
    task automatic resetTest();
        repeat (7) @(posedge CLK_50Mhz);
        @(negedge CLK_50Mhz);
        for (int v = 0; v < 3; v++) begin
            checkValue(sampleName(v), voiceSample(v), 16'h0);
            checkValue(pulseName(v), 16'(voicePulse(v)), 16'h0);
        end
        @(posedge CLK_50Mhz);
        reset_n <= 1'b1;
        repeat (2 * FRAME) begin
            @(negedge CLK_50Mhz);
            for (int v = 0; v < 3; v++) begin
                checkValue(sampleName(v), voiceSample(v), 16'h0);
                checkValue(pulseName(v), 16'(voicePulse(v)), 16'h0);
            end
        end
    endtask

    task automatic fixedTest();
        driveReqs(makeReqs(5, 100, 17, 200, 42, 300));
        settle();
        for (int v = 0; v < 3; v++) checkVoice(v);
    endtask

    // song0's length moves both later regions
    task automatic baseTest();
        driveReqs(makeReqs(5, 250, 17, 200, 42, 300));
        settle();
        checkVoice(1);
        checkVoice(2);
        driveReqs(makeReqs(5, 40, 17, 90, 42, 300));
        settle();
        checkVoice(1);
        checkVoice(2);
    endtask

    task automatic rangeStep(input audio_pkg::voiceReqs_t newReqs, input int skipped);
        logic [15:0] held;
        int          pulses [3];
        held = expectedSample(skipped, reqs);   // Last word read before the skip
        driveReqs(newReqs);
        settle();
        pulses = '{0, 0, 0};
        repeat (3 * FRAME) begin
            @(negedge CLK_50Mhz);
            for (int v = 0; v < 3; v++) begin
                if (voicePulse(v)) pulses[v]++;
            end
        end
        for (int v = 0; v < 3; v++) begin
            checkValue({pulseName(v), " count"}, 16'(pulses[v]), (v == skipped) ? 16'd0 : 16'd3);
        end
        checkValue(sampleName(skipped), voiceSample(skipped), held);
        for (int v = 0; v < 3; v++) begin
            if (v != skipped) checkVoice(v);
        end
    endtask

    task automatic rangeTest();
        rangeStep(makeReqs(5, 100, 200, 200, 42, 300), 1);     // Index equals length
        rangeStep(makeReqs(5, 600, 10, 300, 150, 200), 2);     // Bee runs past the ROM
        rangeStep(makeReqs(100, 100, 10, 300, 42, 300), 0);
    endtask

    // Width and period both show in the spacing of pulses
    task automatic pulseTest();
        int lastSeen [3];
        int pulses   [3];
        driveReqs(makeReqs(3, 50, 9, 60, 11, 70));
        settle();
        lastSeen = '{-1, -1, -1};
        pulses   = '{0, 0, 0};
        for (int c = 0; c < 10 * FRAME; c++) begin
            @(negedge CLK_50Mhz);
            for (int v = 0; v < 3; v++) begin
                if (voicePulse(v)) begin
                    if (lastSeen[v] >= 0) begin
                        checkValue({pulseName(v), " spacing"}, 16'(c - lastSeen[v]),
                                   16'(FRAME));
                    end
                    lastSeen[v] = c;
                    pulses[v]++;
                end
            end
        end
        for (int v = 0; v < 3; v++) begin
            checkValue({pulseName(v), " count"}, 16'(pulses[v]), 16'd10);
        end
    endtask

    // Regions fill the whole ROM
    task automatic randomTest();
        audio_pkg::voiceReqs_t r;
        int                    rnd;
        for (int n = 0; n < 30; n++) begin
            r = makeReqs(0, 300, 0, 400, 0, 324);
            randomBits(10, rnd);
            r.song0.index = 16'(rnd % 300);
            randomBits(10, rnd);
            r.song1.index = 16'(rnd % 400);
            randomBits(10, rnd);
            r.bee.index   = 16'(rnd % 324);
            driveReqs(r);
            settle();
            for (int v = 0; v < 3; v++) checkVoice(v);
        end
    endtask

    initial begin
        reset_n = 1'b0;
        reqs    = '0;
        resetTest();
        fixedTest();
        baseTest();
        rangeTest();
        pulseTest();
        randomTest();
        errorCount += uut.slotSeq.seqChk.assertFails;
        $display("Errors: %0d, assertion failures: %0d", errorCount,
                 uut.slotSeq.seqChk.assertFails);
        if (errorCount == 0) begin
            $display("STATUS: PASS");
        end
        else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+include
rtl/audio_pkg.sv
rtl/slotSequencer.sv
rtl/sampleRom.sv
rtl/voiceLatch.sv
rtl/audioRomSubsystem.sv
testbench/audioRom_chk.sv
testbench/tb_audioRomSubsystem.sv

// ==== Bender.yml ====
package:
  name: audio_rom_subsystem

sources:
  - include_dirs:
      - include
    files:
      - rtl/audio_pkg.sv
      - rtl/slotSequencer.sv
      - rtl/sampleRom.sv
      - rtl/voiceLatch.sv
      - rtl/audioRomSubsystem.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/audioRom_chk.sv
      - testbench/tb_audioRomSubsystem.sv
